//--- logic/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

	// two instructions per fetch, one 64-bit cache line
	localparam int FETCH_NUM = 2;
	localparam int FETCH_WIDTH = $clog2(FETCH_NUM);
	localparam int ALIGN_WIDTH = FETCH_WIDTH + 2;
	localparam int LINE_WIDTH = 32 * FETCH_NUM;
	localparam int COUNT_WIDTH = $clog2(FETCH_NUM + 1);

	localparam logic [31:0] BOOT_VEC = 32'hbfc00000;

	// opcodes seen by the predecoder
	localparam logic [5:0] OP_J = 6'h02;
	localparam logic [5:0] OP_BEQ = 6'h04;
	localparam logic [5:0] OP_BNE = 6'h05;

	typedef logic [31:0] virt_t;

	typedef struct packed {
		logic  read;
		virt_t vaddr;
		logic  flush;
	} icache_req_t;

	// slot 0 sits in the low word
	typedef struct packed {
		logic                  valid;
		logic [LINE_WIDTH-1:0] data;
	} icache_res_t;

	typedef struct packed {
		logic  valid;
		logic  mispredict;
		logic  taken;
		virt_t pc;
		virt_t target;
	} branch_resolved_t;

	typedef struct packed {
		logic  taken;
		virt_t predict_vaddr;
	} branch_predict_t;

	typedef struct packed {
		logic            valid;
		virt_t           vaddr;
		logic [31:0]     instr;
		branch_predict_t branch_predict;
	} fetch_entry_t;

	// number of entries decode takes this cycle
	typedef logic [COUNT_WIDTH-1:0] fetch_ack_t;

	// clear the slot and byte offset within a pair
	function automatic virt_t aligned_address(input virt_t addr);
		return {addr[31:ALIGN_WIDTH], {ALIGN_WIDTH{1'b0}}};
	endfunction

endpackage

`default_nettype wire

//--- logic/pc_gen.sv
`default_nettype none
`timescale 1ns/1ps

module pc_gen (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        hold,
	input  logic                        except_valid,
	input  fetch_pkg::virt_t            except_vec,
	input  fetch_pkg::branch_resolved_t resolved_branch,
	input  logic                        predict_valid,
	input  fetch_pkg::virt_t            predict_vaddr,
	output fetch_pkg::virt_t            pc
);

	import fetch_pkg::*;

	virt_t pc_next;
	virt_t pc_seq;
	virt_t pc_recover;
	logic  mispredict;

	assign mispredict = resolved_branch.valid & resolved_branch.mispredict;

	// next pair after the current line
	assign pc_seq = aligned_address(pc) + virt_t'(FETCH_NUM * 4);

	// resume at the real outcome of the branch
	assign pc_recover = resolved_branch.taken ? resolved_branch.target
		: resolved_branch.pc + virt_t'(4);

	always_comb begin
		if (except_valid) begin
			pc_next = except_vec;
		end else if (mispredict) begin
			pc_next = pc_recover;
		end else if (predict_valid) begin
			pc_next = predict_vaddr;
		end else if (hold) begin
			// queue has no room, repeat the request
			pc_next = pc;
		end else begin
			pc_next = pc_seq;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= BOOT_VEC;
		end else begin
			pc <= pc_next;
		end
	end

	// redirect sources and the predictor must all hand over word addresses
	pc_word_aligned: assert property (
		@(posedge clk) disable iff (!rst_n)
		pc[1:0] == 2'b00
	) else $error("fetch pc %h is not word aligned", pc);

endmodule

`default_nettype wire

//--- logic/branch_predictor.sv
`default_nettype none
`timescale 1ns/1ps

module branch_predictor #(
	parameter int BHT_SIZE = 64
) (
	input  logic                                              clk,
	input  logic                                              rst_n,
	input  fetch_pkg::virt_t                                  pc,
	input  logic [fetch_pkg::FETCH_NUM-1:0][31:0]             instr,
	input  logic [fetch_pkg::FETCH_NUM-1:0]                   instr_valid,
	input  fetch_pkg::branch_resolved_t                       resolved_branch,
	output logic                                              valid,
	output logic [fetch_pkg::FETCH_NUM-1:0]                   taken_slot,
	output fetch_pkg::virt_t                                  predict_vaddr,
	output fetch_pkg::branch_predict_t [fetch_pkg::FETCH_NUM-1:0] bp
);

	import fetch_pkg::*;

	localparam int IDX_WIDTH = $clog2(BHT_SIZE);

	// 2-bit saturating counters, taken at 2 and above
	logic [1:0] bht [BHT_SIZE];

	virt_t [FETCH_NUM-1:0] slot_vaddr;
	virt_t [FETCH_NUM-1:0] slot_target;
	logic  [FETCH_NUM-1:0] slot_taken;
	logic  [IDX_WIDTH-1:0] upd_idx;

	always_comb begin : predecode
		logic [5:0]           opcode;
		logic [IDX_WIDTH-1:0] idx;
		virt_t                seq_vaddr;
		virt_t                offset;

		for (int i = 0; i < FETCH_NUM; i++) begin
			slot_vaddr[i] = pc + virt_t'(4 * i);
			seq_vaddr = slot_vaddr[i] + virt_t'(4);
			opcode = instr[i][31:26];
			idx = slot_vaddr[i][IDX_WIDTH+1:2];
			offset = {{14{instr[i][15]}}, instr[i][15:0], 2'b00};
			slot_target[i] = seq_vaddr;
			slot_taken[i] = 1'b0;
			if (instr_valid[i]) begin
				if (opcode == OP_J) begin
					slot_target[i] = {slot_vaddr[i][31:28], instr[i][25:0], 2'b00};
					slot_taken[i] = 1'b1;
				end else if ((opcode == OP_BEQ || opcode == OP_BNE) && bht[idx][1]) begin
					slot_target[i] = seq_vaddr + offset;
					slot_taken[i] = 1'b1;
				end
			end
		end
	end

	// oldest taken slot decides the redirect
	always_comb begin : taken_select
		logic older_taken;

		older_taken = 1'b0;
		predict_vaddr = '0;
		for (int i = 0; i < FETCH_NUM; i++) begin
			taken_slot[i] = slot_taken[i] & ~older_taken;
			if (taken_slot[i]) begin
				predict_vaddr = slot_target[i];
			end
			older_taken = older_taken | slot_taken[i];
		end
	end

	assign valid = |slot_taken;

	always_comb begin
		for (int i = 0; i < FETCH_NUM; i++) begin
			bp[i].taken = taken_slot[i];
			bp[i].predict_vaddr = slot_target[i];
		end
	end

	assign upd_idx = resolved_branch.pc[IDX_WIDTH+1:2];

	// jumps resolve taken as well but never read the table
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < BHT_SIZE; i++) begin
				bht[i] <= 2'b01;
			end
		end else if (resolved_branch.valid) begin
			if (resolved_branch.taken && bht[upd_idx] != 2'b11) begin
				bht[upd_idx] <= bht[upd_idx] + 2'b01;
			end else if (!resolved_branch.taken && bht[upd_idx] != 2'b00) begin
				bht[upd_idx] <= bht[upd_idx] - 2'b01;
			end
		end
	end

	// top level masks on this being one-hot
	taken_slot_onehot: assert property (
		@(posedge clk) disable iff (!rst_n)
		$onehot0(taken_slot)
	) else $error("more than one taken slot: %b", taken_slot);

endmodule

`default_nettype wire

//--- logic/instr_queue.sv
`default_nettype none
`timescale 1ns/1ps

module instr_queue #(
	parameter int QUEUE_DEPTH = 8
) (
	input  logic                                               clk,
	input  logic                                               rst_n,
	input  logic                                               flush,
	input  fetch_pkg::fetch_entry_t [fetch_pkg::FETCH_NUM-1:0] push_entry,
	input  logic [fetch_pkg::COUNT_WIDTH-1:0]                  push_num,
	output logic                                               full,
	input  fetch_pkg::fetch_ack_t                              fetch_ack,
	output fetch_pkg::fetch_entry_t [fetch_pkg::FETCH_NUM-1:0] fetch_entry
);

	import fetch_pkg::*;

	localparam int PTR_WIDTH = $clog2(QUEUE_DEPTH);
	localparam int CNT_WIDTH = PTR_WIDTH + 1;

	fetch_entry_t mem [QUEUE_DEPTH];

	logic [PTR_WIDTH-1:0] head;
	logic [PTR_WIDTH-1:0] tail;
	logic [CNT_WIDTH-1:0] count;
	logic [CNT_WIDTH-1:0] count_next;

	// room must remain for the line already in flight
	assign full = count > CNT_WIDTH'(QUEUE_DEPTH - 2 * FETCH_NUM);

	assign count_next = count + CNT_WIDTH'(push_num) - CNT_WIDTH'(fetch_ack);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			head <= '0;
			tail <= '0;
			count <= '0;
		end else if (flush) begin
			head <= '0;
			tail <= '0;
			count <= '0;
		end else begin
			head <= head + PTR_WIDTH'(fetch_ack);
			tail <= tail + PTR_WIDTH'(push_num);
			count <= count_next;
		end
	end

	// payload storage
	always_ff @(posedge clk) begin
		if (!flush) begin
			for (int i = 0; i < FETCH_NUM; i++) begin
				if (i < push_num) begin
					mem[tail + PTR_WIDTH'(i)] <= push_entry[i];
				end
			end
		end
	end

	// oldest entries first, valid from occupancy
	always_comb begin
		for (int i = 0; i < FETCH_NUM; i++) begin
			fetch_entry[i] = mem[head + PTR_WIDTH'(i)];
			fetch_entry[i].valid = CNT_WIDTH'(i) < count;
		end
	end

	// decode may only take what is shown as valid
	ack_within_count: assert property (
		@(posedge clk) disable iff (!rst_n)
		!flush |-> CNT_WIDTH'(fetch_ack) <= count
	) else $error("fetch_ack %0d exceeds occupancy %0d", fetch_ack, count);

	// fetch hold must stop pushes before the buffer wraps
	push_within_depth: assert property (
		@(posedge clk) disable iff (!rst_n)
		!flush |-> (count + push_num) <= QUEUE_DEPTH
	) else $error("push of %0d overflows queue at %0d", push_num, count);

endmodule

`default_nettype wire

//--- logic/instr_fetch.sv
`default_nettype none
`timescale 1ns/1ps

module instr_fetch #(
	parameter int BHT_SIZE = 64
) (
	input  logic                                               clk,
	input  logic                                               rst_n,
	input  logic                                               except_valid,
	input  fetch_pkg::virt_t                                   except_vec,
	input  fetch_pkg::branch_resolved_t                        resolved_branch,
	output fetch_pkg::icache_req_t                             icache_req,
	input  fetch_pkg::icache_res_t                             icache_res,
	input  fetch_pkg::fetch_ack_t                              fetch_ack,
	output fetch_pkg::fetch_entry_t [fetch_pkg::FETCH_NUM-1:0] fetch_entry
);

	import fetch_pkg::*;

	// stage 1
	virt_t pc;
	logic  queue_full;
	logic  redirect;

	// stage 2
	virt_t                      s2_vaddr;
	logic                       squash;
	virt_t                      line_vaddr;
	logic [FETCH_WIDTH-1:0]     fetch_offset;
	logic [FETCH_NUM-1:0][31:0] instr;
	logic [FETCH_NUM-1:0]       instr_valid;
	logic [FETCH_NUM-1:0]       slot_keep;

	logic                              predict_valid;
	logic [FETCH_NUM-1:0]              taken_slot;
	virt_t                             predict_vaddr;
	branch_predict_t [FETCH_NUM-1:0]   bp;
	fetch_entry_t [FETCH_NUM-1:0]      push_entry;
	logic [COUNT_WIDTH-1:0]            push_num;

	// exception or mispredict throws away all younger work
	assign redirect = except_valid | (resolved_branch.valid & resolved_branch.mispredict);

	assign icache_req.read = 1'b1;
	assign icache_req.vaddr = aligned_address(pc);
	assign icache_req.flush = redirect;

	pc_gen pc_gen_i (
		.clk             ( clk             ),
		.rst_n           ( rst_n           ),
		.hold            ( queue_full      ),
		.except_valid    ( except_valid    ),
		.except_vec      ( except_vec      ),
		.resolved_branch ( resolved_branch ),
		.predict_valid   ( predict_valid   ),
		.predict_vaddr   ( predict_vaddr   ),
		.pc              ( pc              )
	);

	// the line arriving next cycle is stale after a redirect, a prediction or a hold
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			s2_vaddr <= BOOT_VEC;
			squash <= 1'b1;
		end else begin
			s2_vaddr <= pc;
			squash <= redirect | predict_valid | queue_full;
		end
	end

	assign line_vaddr = aligned_address(s2_vaddr);
	assign fetch_offset = s2_vaddr[ALIGN_WIDTH-1:2];

	// unpack the line, slots before the offset were not asked for
	always_comb begin
		for (int i = 0; i < FETCH_NUM; i++) begin
			instr[i] = icache_res.data[32*i +: 32];
			instr_valid[i] = icache_res.valid & ~squash
				& (FETCH_WIDTH'(i) >= fetch_offset);
		end
	end

	branch_predictor #(
		.BHT_SIZE ( BHT_SIZE )
	) branch_predictor_i (
		.clk             ( clk             ),
		.rst_n           ( rst_n           ),
		.pc              ( line_vaddr      ),
		.instr           ( instr           ),
		.instr_valid     ( instr_valid     ),
		.resolved_branch ( resolved_branch ),
		.valid           ( predict_valid   ),
		.taken_slot      ( taken_slot      ),
		.predict_vaddr   ( predict_vaddr   ),
		.bp              ( bp              )
	);

	// drop slots behind a taken branch, pack the rest from index 0
	always_comb begin : compact
		logic        seen_taken;
		int unsigned n;

		seen_taken = 1'b0;
		n = 0;
		push_entry = '0;
		for (int i = 0; i < FETCH_NUM; i++) begin
			slot_keep[i] = instr_valid[i] & ~seen_taken;
			seen_taken = seen_taken | taken_slot[i];
			if (slot_keep[i]) begin
				push_entry[n].valid = 1'b1;
				push_entry[n].vaddr = line_vaddr + virt_t'(4 * i);
				push_entry[n].instr = instr[i];
				push_entry[n].branch_predict = bp[i];
				n++;
			end
		end
		push_num = COUNT_WIDTH'(n);
	end

	instr_queue instr_queue_i (
		.clk         ( clk         ),
		.rst_n       ( rst_n       ),
		.flush       ( redirect    ),
		.push_entry  ( push_entry  ),
		.push_num    ( push_num    ),
		.full        ( queue_full  ),
		.fetch_ack   ( fetch_ack   ),
		.fetch_entry ( fetch_entry )
	);

	// nothing old may reach decode right after a redirect
	redirect_empties_queue: assert property (
		@(posedge clk) disable iff (!rst_n)
		redirect |=> !fetch_entry[0].valid
	) else $error("entry still valid after redirect");

endmodule

`default_nettype wire

//--- testbench/icache_model.sv
`default_nettype none
`timescale 1ns/1ps

module icache_model (
	input  logic                   clk,
	input  logic                   rst_n,
	input  fetch_pkg::icache_req_t icache_req,
	output fetch_pkg::icache_res_t icache_res
);

	import fetch_pkg::*;

	localparam int IMAGE_WORDS = 1024;
	localparam int IDX_WIDTH = $clog2(IMAGE_WORDS);

	// program image, aliased every 4 KiB, written by the tests
	logic [31:0] mem [IMAGE_WORDS];

	logic [IDX_WIDTH-1:0] base;

	// first word of the requested pair
	assign base = {icache_req.vaddr[IDX_WIDTH+1:ALIGN_WIDTH], {FETCH_WIDTH{1'b0}}};

	// one-cycle registered response, nothing returned for a flushed request
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			icache_res <= '0;
		end else begin
			icache_res.valid <= icache_req.read & ~icache_req.flush;
			for (int i = 0; i < FETCH_NUM; i++) begin
				icache_res.data[32*i +: 32] <= mem[base + IDX_WIDTH'(i)];
			end
		end
	end

endmodule

`default_nettype wire

//--- testbench/tb_fetch.sv
`default_nettype none
`timescale 1ns/1ps

module tb_fetch;

	import fetch_pkg::*;

	localparam int CLK_PERIOD = 10;
	localparam int RESET_CYCLES = 10;
	localparam int BHT_ENTRIES = 64;
	localparam int BHT_BITS = $clog2(BHT_ENTRIES);
	localparam int DECODE_LIMIT = 300;
	localparam int NUM_TESTS = 5;
	localparam int NUM_DECODE_RUNS = 10;
	localparam int WATCHDOG_CYCLES = NUM_TESTS * (RESET_CYCLES + 40)
		+ NUM_DECODE_RUNS * (DECODE_LIMIT + 2) + 200;

	logic                          clk;
	logic                          rst_n;
	logic                          except_valid;
	virt_t                         except_vec;
	branch_resolved_t              resolved_branch;
	icache_req_t                   icache_req;
	icache_res_t                   icache_res;
	fetch_ack_t                    fetch_ack;
	fetch_entry_t [FETCH_NUM-1:0]  fetch_entry;

	integer       seed;
	int           error_count;
	int           check_count;
	int           test_count;
	int           failed_tests;
	int           errors_before;
	int unsigned  ctr [BHT_ENTRIES];
	fetch_entry_t got[$];
	fetch_entry_t expected[$];

	instr_fetch #(
		.BHT_SIZE ( BHT_ENTRIES )
	) dut_i (
		.clk             ( clk             ),
		.rst_n           ( rst_n           ),
		.except_valid    ( except_valid    ),
		.except_vec      ( except_vec      ),
		.resolved_branch ( resolved_branch ),
		.icache_req      ( icache_req      ),
		.icache_res      ( icache_res      ),
		.fetch_ack       ( fetch_ack       ),
		.fetch_entry     ( fetch_entry     )
	);

	icache_model cache_i (
		.clk        ( clk        ),
		.rst_n      ( rst_n      ),
		.icache_req ( icache_req ),
		.icache_res ( icache_res )
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// ori words only, so the default image never branches
	function automatic logic [31:0] pattern_word(input logic [9:0] idx);
		return {6'h0d, idx[9:5], idx[4:0], ~idx[5:0], idx};
	endfunction

	task automatic check_value(input string name, input logic [31:0] exp_value,
			input logic [31:0] act_value);
		check_count++;
		if (act_value !== exp_value) begin
			error_count++;
			$display("[ERROR] %0t ns %s: expected %h, got %h", $time, name, exp_value, act_value);
		end
	endtask

	task automatic begin_test();
		errors_before = error_count;
		for (int i = 0; i < 1024; i++) begin
			cache_i.mem[i] = pattern_word(10'(i));
		end
	endtask

	task automatic end_test(input string name);
		test_count++;
		if (error_count == errors_before) begin
			$display("test %s: passed", name);
		end else begin
			failed_tests++;
			$display("test %s: %0d mismatches", name, error_count - errors_before);
		end
	endtask

	task automatic write_word(input virt_t addr, input logic [31:0] word);
		cache_i.mem[addr[11:2]] = word;
	endtask

	task automatic apply_reset();
		@(posedge clk);
		rst_n <= 1'b0;
		fetch_ack <= '0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
		for (int i = 0; i < BHT_ENTRIES; i++) begin
			ctr[i] = 1;
		end
		// first request goes out from the boot vector
		@(negedge clk);
		check_value("icache_req.read", 1, icache_req.read);
		check_value("icache_req.flush", 0, icache_req.flush);
		check_value("icache_req.vaddr", BOOT_VEC, icache_req.vaddr);
		check_value("fetch_entry[0].valid after reset", 0, fetch_entry[0].valid);
	endtask

	// one resolved branch for a cycle, mirrored into the counter model
	task automatic resolve(input logic mispredict, input logic taken, input virt_t br_pc,
			input virt_t target);
		branch_resolved_t r;
		int unsigned      idx;
		virt_t            resume;

		r = '0;
		r.valid = 1'b1;
		r.mispredict = mispredict;
		r.taken = taken;
		r.pc = br_pc;
		r.target = target;
		idx = br_pc[BHT_BITS+1:2];
		resume = taken ? target : br_pc + 32'd4;
		@(posedge clk);
		resolved_branch <= r;
		if (taken && ctr[idx] < 3) begin
			ctr[idx]++;
		end else if (!taken && ctr[idx] > 0) begin
			ctr[idx]--;
		end
		@(negedge clk);
		check_value("icache_req.flush", mispredict, icache_req.flush);
		@(posedge clk);
		resolved_branch <= '0;
		// recovery address goes out on the next request
		if (mispredict) begin
			@(negedge clk);
			check_value("icache_req.vaddr", {resume[31:3], 3'b000}, icache_req.vaddr);
		end
	endtask

	task automatic raise_exception(input virt_t vec);
		@(posedge clk);
		except_valid <= 1'b1;
		except_vec <= vec;
		@(negedge clk);
		check_value("icache_req.flush", 1, icache_req.flush);
		@(posedge clk);
		except_valid <= 1'b0;
		@(negedge clk);
		check_value("icache_req.vaddr", {vec[31:3], 3'b000}, icache_req.vaddr);
	endtask

	// decode model: looks at the head at negedge, acks on the next rising edge
	task automatic decode(input int want, input bit random_ack, input int hold_cycles);
		int cycles;
		int avail;
		int n;

		got.delete();
		cycles = 0;
		while (got.size() < want && cycles < DECODE_LIMIT) begin
			@(negedge clk);
			n = 0;
			if (fetch_ack == '0 && cycles >= hold_cycles) begin
				avail = fetch_entry[0].valid ? (fetch_entry[1].valid ? 2 : 1) : 0;
				n = random_ack ? $unsigned($random(seed)) % 3 : 2;
				if (n > avail) begin
					n = avail;
				end
				if (n > want - got.size()) begin
					n = want - got.size();
				end
				for (int i = 0; i < n; i++) begin
					got.push_back(fetch_entry[i]);
				end
			end
			@(posedge clk);
			fetch_ack <= fetch_ack_t'(n);
			cycles++;
		end
		@(posedge clk);
		fetch_ack <= '0;
		if (got.size() < want) begin
			error_count++;
			$display("decode model gave up after %0d cycles with %0d of %0d entries",
				cycles, got.size(), want);
		end
	endtask

	// walk the image from start, following J and trained conditional branches
	function automatic void build_reference(input virt_t start, input int num);
		virt_t        addr;
		virt_t        next;
		virt_t        offset;
		logic [31:0]  word;
		logic [5:0]   op;
		fetch_entry_t e;

		expected.delete();
		addr = start;
		for (int i = 0; i < num; i++) begin
			word = cache_i.mem[addr[11:2]];
			op = word[31:26];
			offset = {{14{word[15]}}, word[15:0], 2'b00};
			next = addr + 32'd4;
			e = '0;
			e.valid = 1'b1;
			e.vaddr = addr;
			e.instr = word;
			if (op == OP_J) begin
				e.branch_predict.taken = 1'b1;
				next = {addr[31:28], word[25:0], 2'b00};
			end else if ((op == OP_BEQ || op == OP_BNE) && ctr[addr[BHT_BITS+1:2]] >= 2) begin
				e.branch_predict.taken = 1'b1;
				next = addr + 32'd4 + offset;
			end
			e.branch_predict.predict_vaddr = next;
			expected.push_back(e);
			addr = next;
		end
	endfunction

	task automatic decode_and_compare(input virt_t start, input int num, input bit random_ack,
			input int hold_cycles);
		fetch_entry_t e;
		fetch_entry_t g;

		decode(num, random_ack, hold_cycles);
		build_reference(start, num);
		check_value("accepted entry count", expected.size(), got.size());
		for (int i = 0; i < expected.size() && i < got.size(); i++) begin
			e = expected[i];
			g = got[i];
			check_value($sformatf("entry[%0d].vaddr", i), e.vaddr, g.vaddr);
			check_value($sformatf("entry[%0d].instr", i), e.instr, g.instr);
			check_value($sformatf("entry[%0d].taken", i), e.branch_predict.taken,
				g.branch_predict.taken);
			if (e.branch_predict.taken) begin
				check_value($sformatf("entry[%0d].predict_vaddr", i),
					e.branch_predict.predict_vaddr, g.branch_predict.predict_vaddr);
			end
		end
	endtask

	task automatic test_straight_line();
		begin_test();
		apply_reset();
		decode_and_compare(BOOT_VEC, 24, 1'b0, 0);
		end_test("straight line");
	endtask

	task automatic test_jump_and_fall_through();
		begin_test();
		// J lands on slot 1 of a pair, BEQ with an untrained counter
		write_word(BOOT_VEC + 32'h08, {OP_J, 26'((BOOT_VEC + 32'h44) >> 2)});
		write_word(BOOT_VEC + 32'h4c, {OP_BEQ, 5'd1, 5'd2, 16'h0010});
		apply_reset();
		decode_and_compare(BOOT_VEC, 12, 1'b0, 0);
		end_test("jump and fall through");
	endtask

	task automatic test_trained_loop();
		virt_t loop_pc;

		loop_pc = BOOT_VEC + 32'h100;
		begin_test();
		// three-word loop closed by a backward BEQ
		write_word(loop_pc + 32'h8, {OP_BEQ, 5'd3, 5'd3, 16'hfffd});
		apply_reset();
		resolve(1'b0, 1'b1, loop_pc + 32'h8, loop_pc);
		resolve(1'b0, 1'b1, loop_pc + 32'h8, loop_pc);
		resolve(1'b1, 1'b1, loop_pc + 32'h8, loop_pc);
		decode_and_compare(loop_pc, 12, 1'b0, 0);
		end_test("trained loop");
	endtask

	task automatic check_redirect(input bit exception, input logic taken, input virt_t addr,
			input virt_t target, input virt_t resume);
		decode(2, 1'b0, 0);
		repeat (3) @(posedge clk);
		@(negedge clk);
		check_value("fetch_entry[0].valid before redirect", 1, fetch_entry[0].valid);
		if (exception) begin
			raise_exception(addr);
		end else begin
			resolve(1'b1, taken, addr, target);
		end
		decode_and_compare(resume, 6, 1'b0, 0);
	endtask

	task automatic test_redirects();
		begin_test();
		apply_reset();
		check_redirect(1'b0, 1'b1, BOOT_VEC + 32'h14, BOOT_VEC + 32'h200, BOOT_VEC + 32'h200);
		check_redirect(1'b0, 1'b0, BOOT_VEC + 32'h234, BOOT_VEC + 32'h300, BOOT_VEC + 32'h238);
		check_redirect(1'b1, 1'b0, BOOT_VEC + 32'h180, '0, BOOT_VEC + 32'h180);
		end_test("redirects");
	endtask

	task automatic test_back_pressure();
		begin_test();
		apply_reset();
		decode_and_compare(BOOT_VEC, 24, 1'b1, 20);
		end_test("back pressure");
	endtask

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		except_valid = 1'b0;
		except_vec = '0;
		resolved_branch = '0;
		fetch_ack = '0;
		seed = 32'h1cf5ff3a;
		error_count = 0;
		check_count = 0;
		test_count = 0;
		failed_tests = 0;
		test_straight_line();
		test_jump_and_fall_through();
		test_trained_loop();
		test_redirects();
		test_back_pressure();
		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			test_count, failed_tests, check_count, error_count);
		if (failed_tests == 0 && error_count == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	// budget covers every reset and decode run
	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("watchdog expired after %0d cycles, tests did not finish", WATCHDOG_CYCLES);
		$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- sources.f
logic/fetch_pkg.sv
logic/pc_gen.sv
logic/branch_predictor.sv
logic/instr_queue.sv
logic/instr_fetch.sv
testbench/icache_model.sv
testbench/tb_fetch.sv

//--- Bender.yml
package:
  name: instr_fetch

sources:
  - logic/fetch_pkg.sv
  - logic/pc_gen.sv
  - logic/branch_predictor.sv
  - logic/instr_queue.sv
  - logic/instr_fetch.sv
  - target: test
    files:
      - testbench/icache_model.sv
      - testbench/tb_fetch.sv
